// ==== rtl/rv_csr_file.sv ====
`timescale 1ns/1ps

module rv_csr_file import rv_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            valid,
	input  decoded_inst_t   dec,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	output logic [XLEN-1:0] csr_rdata,
	output redirect_t       csr_redirect
);

	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;
	logic [XLEN-1:0] mscratch;
	logic [XLEN-1:0] csr_new;
	logic            csr_wen;

	always_comb begin
		case (dec.csr_addr)
			CSR_MTVEC: csr_rdata = mtvec;
			CSR_MEPC: csr_rdata = mepc;
			CSR_MCAUSE: csr_rdata = mcause;
			CSR_MSCRATCH: csr_rdata = mscratch;
			default: csr_rdata = '0;
		endcase
	end

	// Read-modify-write value
	always_comb begin
		case (dec.csr_op)
			CSR_WRITE: csr_new = src1;
			CSR_SET: csr_new = csr_rdata | src1;
			CSR_CLEAR: csr_new = csr_rdata & ~src1;
			default: csr_new = csr_rdata;
		endcase
	end

	assign csr_wen = valid && (dec.csr_op != CSR_NONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
			mscratch <= '0;
		end else if (valid && dec.is_ecall) begin
			mepc <= pc;
			mcause <= CAUSE_ECALL_M;
		end else if (csr_wen) begin
			case (dec.csr_addr)
				CSR_MTVEC: mtvec <= csr_new;
				CSR_MEPC: mepc <= csr_new;
				CSR_MCAUSE: mcause <= csr_new;
				CSR_MSCRATCH: mscratch <= csr_new;
				default: ;
			endcase
		end
	end

	assign csr_redirect.take = dec.is_ecall || dec.is_mret;
	assign csr_redirect.target = dec.is_ecall ? mtvec : mepc;

endmodule

// ==== rtl/rv_exu.sv ====
`timescale 1ns/1ps

module rv_exu import rv_pkg::*; (
	input  decoded_inst_t   dec,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] csr_rdata,
	output logic [XLEN-1:0] wb_data,
	output redirect_t       exu_redirect
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] link;
	logic            br_taken;

	assign op_a = dec.use_pc ? pc : src1;
	assign op_b = dec.use_imm ? dec.imm : src2;

	// ******************************
	// ALU
	// ******************************
	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_out = op_a + op_b;
			ALU_SUB: alu_out = op_a - op_b;
			ALU_SLL: alu_out = op_a << op_b[4:0];
			ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SRL: alu_out = op_a >> op_b[4:0];
			ALU_SRA: alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR: alu_out = op_a | op_b;
			ALU_AND: alu_out = op_a & op_b;
			default: alu_out = op_b;
		endcase
	end

	// ******************************
	// Branches and jumps
	// ******************************
	always_comb begin
		case (dec.funct3)
			3'b000: br_taken = (src1 == src2);
			3'b001: br_taken = (src1 != src2);
			3'b100: br_taken = ($signed(src1) < $signed(src2));
			3'b101: br_taken = ($signed(src1) >= $signed(src2));
			3'b110: br_taken = (src1 < src2);
			3'b111: br_taken = (src1 >= src2);
			default: br_taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec.is_jalr)
			target = (src1 + dec.imm) & ~32'd1;
		else
			target = pc + dec.imm;
	end

	assign link = pc + 32'd4;

	assign exu_redirect.take = (dec.is_branch && br_taken) || dec.is_jal || dec.is_jalr;
	assign exu_redirect.target = target;

	always_comb begin
		if (dec.is_jal || dec.is_jalr)
			wb_data = link;
		else if (dec.cls == CLASS_CSR)
			wb_data = csr_rdata;
		else
			wb_data = alu_out;
	end

endmodule

// ==== rtl/rv_idu.sv ====
`timescale 1ns/1ps

module rv_idu import rv_pkg::*; (
	input  logic [XLEN-1:0] inst,
	output decoded_inst_t   dec
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            alt;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	alu_op_t         f3_op;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt = inst[30];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct3 to ALU op, shared by OP and OP-IMM
	always_comb begin
		case (funct3)
			3'b001: f3_op = ALU_SLL;
			3'b010: f3_op = ALU_SLT;
			3'b011: f3_op = ALU_SLTU;
			3'b100: f3_op = ALU_XOR;
			3'b101: f3_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: f3_op = ALU_OR;
			3'b111: f3_op = ALU_AND;
			default: f3_op = ALU_ADD;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.rd = inst[11:7];
		dec.funct3 = funct3;
		dec.csr_addr = inst[31:20];
		dec.imm = imm_i;
		dec.cls = CLASS_SYSTEM;
		dec.alu_op = ALU_ADD;
		dec.csr_op = CSR_NONE;
		case (opcode)
			OP_LUI: begin
				dec.cls = CLASS_U;
				dec.imm = imm_u;
				dec.alu_op = ALU_PASS_B;
				dec.use_imm = 1'b1;
			end
			OP_AUIPC: begin
				dec.cls = CLASS_U;
				dec.imm = imm_u;
				dec.use_imm = 1'b1;
				dec.use_pc = 1'b1;
			end
			OP_JAL: begin
				dec.cls = CLASS_J;
				dec.imm = imm_j;
				dec.use_imm = 1'b1;
				dec.use_pc = 1'b1;
				dec.is_jal = 1'b1;
			end
			OP_JALR: begin
				dec.cls = CLASS_I;
				dec.use_imm = 1'b1;
				dec.is_jalr = 1'b1;
			end
			OP_BRANCH: begin
				dec.cls = CLASS_B;
				dec.imm = imm_b;
				dec.alu_op = ALU_SUB;
				dec.is_branch = 1'b1;
			end
			// No data memory, decoded as a no-op
			OP_STORE: dec.imm = imm_s;
			OP_IMM: begin
				dec.cls = CLASS_I;
				dec.use_imm = 1'b1;
				dec.alu_op = f3_op;
			end
			OP_REG: begin
				dec.cls = CLASS_R;
				dec.alu_op = (funct3 == 3'b000 && alt) ? ALU_SUB : f3_op;
			end
			OP_SYSTEM: begin
				if (funct3 inside {3'b001, 3'b010, 3'b011}) begin
					dec.cls = CLASS_CSR;
					dec.csr_op = csr_op_t'(funct3[1:0]);
				end else begin
					dec.is_ecall = (inst == INST_ECALL);
					dec.is_mret = (inst == INST_MRET);
					dec.is_ebreak = (inst == INST_EBREAK);
				end
			end
			default: ;
		endcase
		dec.reg_wen = (dec.cls inside {CLASS_R, CLASS_I, CLASS_U, CLASS_J, CLASS_CSR})
			&& (dec.rd != 5'd0);
	end

endmodule

// ==== rtl/rv_ifu.sv ====
`timescale 1ns/1ps

module rv_ifu import rv_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000,
	parameter int IMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  logic [XLEN-1:0]               imem_wdata,
	input  logic                          is_ebreak,
	input  redirect_t                     exu_redirect,
	input  redirect_t                     csr_redirect,
	output logic [XLEN-1:0]               pc,
	output logic [XLEN-1:0]               inst,
	output logic                          valid,
	output logic                          finished
);

	localparam int AW = $clog2(IMEM_DEPTH);

	typedef enum logic [1:0] {FETCH, EXEC, HALT} state_t;

	state_t          state;
	logic [XLEN-1:0] imem [IMEM_DEPTH];
	logic [XLEN-1:0] next_pc;

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// Word-addressed fetch
	always_ff @(posedge clk) begin
		if (state == FETCH)
			inst <= imem[pc[AW+1:2]];
	end

	assign valid = (state == EXEC);
	assign finished = valid && is_ebreak;

	// Trap/return wins over jumps
	always_comb begin
		if (csr_redirect.take)
			next_pc = csr_redirect.target;
		else if (exu_redirect.take)
			next_pc = exu_redirect.target;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH;
			pc <= RESET_PC;
		end else begin
			case (state)
				FETCH: state <= EXEC;
				EXEC: begin
					if (is_ebreak) begin
						state <= HALT;
					end else begin
						state <= FETCH;
						pc <= next_pc;
					end
				end
				default: state <= HALT;
			endcase
		end
	end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN = 32;

	// ******************************
	// Encodings
	// ******************************
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [XLEN-1:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [XLEN-1:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [XLEN-1:0] INST_MRET   = 32'h3020_0073;

	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;

	localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

	typedef enum logic [2:0] {
		CLASS_R,
		CLASS_I,
		CLASS_U,
		CLASS_J,
		CLASS_B,
		CLASS_CSR,
		CLASS_SYSTEM
	} inst_class_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

	// Same order as funct3[1:0] of csrrw/csrrs/csrrc
	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_WRITE,
		CSR_SET,
		CSR_CLEAR
	} csr_op_t;

	// ******************************
	// Shared structs
	// ******************************
	typedef struct packed {
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [2:0]      funct3;
		logic [XLEN-1:0] imm;
		inst_class_t     cls;
		alu_op_t         alu_op;
		csr_op_t         csr_op;
		logic [11:0]     csr_addr;
		logic            reg_wen;
		logic            use_imm;
		logic            use_pc;
		logic            is_branch;
		logic            is_jal;
		logic            is_jalr;
		logic            is_ecall;
		logic            is_mret;
		logic            is_ebreak;
	} decoded_inst_t;

	typedef struct packed {
		logic            take;
		logic [XLEN-1:0] target;
	} redirect_t;

endpackage

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            valid,
	input  decoded_inst_t   dec,
	input  logic [XLEN-1:0] wb_data,
	output logic [XLEN-1:0] src1,
	output logic [XLEN-1:0] src2,
	output logic [XLEN-1:0] a0_value
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (valid && dec.reg_wen) begin
			regs[dec.rd] <= wb_data;
		end
	end

	// x0 reads zero
	assign src1 = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
	assign src2 = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

	assign a0_value = regs[10];

endmodule

// ==== rtl/rv_top.sv ====
`timescale 1ns/1ps

module rv_top import rv_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000,
	parameter int IMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  logic [XLEN-1:0]               imem_wdata,
	output logic [XLEN-1:0]               pc,
	output logic                          valid,
	output logic                          finished,
	output logic [XLEN-1:0]               halt_ret
);

	logic [XLEN-1:0] inst;
	decoded_inst_t   dec;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] wb_data;
	logic [XLEN-1:0] csr_rdata;
	redirect_t       exu_redirect;
	redirect_t       csr_redirect;

	rv_ifu #(
		.RESET_PC(RESET_PC),
		.IMEM_DEPTH(IMEM_DEPTH)
	) i_ifu (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.is_ebreak(dec.is_ebreak),
		.exu_redirect(exu_redirect),
		.csr_redirect(csr_redirect),
		.pc(pc),
		.inst(inst),
		.valid(valid),
		.finished(finished)
	);

	rv_idu i_idu (
		.inst(inst),
		.dec(dec)
	);

	rv_regfile i_regfile (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.dec(dec),
		.wb_data(wb_data),
		.src1(src1),
		.src2(src2),
		.a0_value(halt_ret)
	);

	rv_exu i_exu (
		.dec(dec),
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.csr_rdata(csr_rdata),
		.wb_data(wb_data),
		.exu_redirect(exu_redirect)
	);

	rv_csr_file i_csr_file (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.dec(dec),
		.pc(pc),
		.src1(src1),
		.csr_rdata(csr_rdata),
		.csr_redirect(csr_redirect)
	);

endmodule

// ==== rv_core.f ====
+incdir+verif
rtl/rv_pkg.sv
rtl/rv_ifu.sv
rtl/rv_idu.sv
rtl/rv_regfile.sv
rtl/rv_exu.sv
rtl/rv_csr_file.sv
rtl/rv_top.sv
verif/rv_top_tb.sv

// ==== verif/rv_prog_table.svh ====
`ifndef RV_PROG_TABLE_SVH
`define RV_PROG_TABLE_SVH

// Columns: first word in PROG_WORDS, word count, a0 at halt,
// pc of the ebreak, valid strobes including the ebreak
typedef struct packed {
	logic [7:0]  base;
	logic [7:0]  n_words;
	logic [31:0] exp_ret;
	logic [31:0] exp_pc;
	logic [15:0] exp_strobes;
} prog_entry_t;

localparam int N_PROGS = 4;
localparam int N_WORDS = 57;

localparam logic [31:0] PROG_WORDS [N_WORDS] = '{
	// ******************************
	// Arithmetic, lui, auipc, x0 write
	// ******************************
	32'h0640_0293, 32'hFF90_0313, 32'h0062_83B3, 32'h4062_8433,
	32'h0043_9493, 32'h4013_5593, 32'h01C3_5613, 32'h0053_26B3,
	32'h0053_3733, 32'h0082_C7B3, 32'h00C4_E833, 32'h0088_78B3,
	32'h1234_5937, 32'h0000_1997, 32'h0052_8013,
	// Fold the results into a0, last add reads x0
	32'h0139_0533, 32'h0115_0533, 32'h00F5_4533, 32'h40B5_0533,
	32'h00C5_0533, 32'h00D5_0533, 32'h00E5_0533, 32'h0005_0533,
	32'h0010_0073,
	// ******************************
	// Countdown loop, jal and jalr
	// ******************************
	32'h0050_0293, 32'h0000_0513,
	// t0 from 5 down to 0, a0 += 3 per pass
	32'h0035_0513, 32'hFFF2_8293, 32'hFE02_9CE3,
	32'h00C0_00EF, 32'h0645_0513, 32'h0010_0073,
	// Subroutine doubles a0
	32'h0015_1513, 32'h0000_8067,
	// ******************************
	// mscratch write, set, clear
	// ******************************
	32'hA5A5_A2B7, 32'h5A52_8293, 32'h3402_9073, 32'h70A0_0313,
	32'h3403_23F3, 32'hFF00_0337, 32'h3403_3473, 32'h3400_2573,
	32'h4074_05B3, 32'h00B5_0533, 32'h0010_0073,
	// ******************************
	// ecall, handler at 0x18, mret
	// ******************************
	32'h0180_0293, 32'h3052_9073, 32'h0000_0513, 32'h0000_0073,
	32'h7005_6513, 32'h0010_0073,
	// Handler adds mcause to a0 and steps mepc past the ecall
	32'h3420_2373, 32'h0065_0533, 32'h3410_23F3, 32'h0043_8393,
	32'h3413_9073, 32'h3020_0073
};

localparam prog_entry_t PROG_TABLE [N_PROGS] = '{
	'{8'd0, 8'd24, 32'h1234_6084, 32'h0000_005C, 16'd24},
	'{8'd24, 8'd10, 32'h0000_0082, 32'h0000_001C, 16'd22},
	'{8'd34, 8'd11, 32'h00A5_A9B9, 32'h0000_0028, 16'd11},
	'{8'd45, 8'd12, 32'h0000_070B, 32'h0000_0014, 16'd12}
};

`endif

// ==== verif/rv_top_tb.sv ====
`timescale 1ns/1ps

module rv_top_tb import rv_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int HALT_CYCLES = 20;
	localparam int RUN_TIMEOUT = 2000;
	localparam int VALID_TIMEOUT = 10;
	// Fetch overlaps the cycle in which reset falls
	localparam int FIRST_VALID_EDGE = 1;
	localparam int SEED = 19925;
	localparam int IMEM_DEPTH = 256;
	localparam int AW = $clog2(IMEM_DEPTH);
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	`include "rv_prog_table.svh"

	logic            clk;
	logic            reset;
	logic            imem_we;
	logic [AW-1:0]   imem_addr;
	logic [XLEN-1:0] imem_wdata;
	logic [XLEN-1:0] pc;
	logic            valid;
	logic            finished;
	logic [XLEN-1:0] halt_ret;

	rv_top i_dut (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.pc(pc),
		.valid(valid),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ******************************
	// Failure handling
	// ******************************
	task automatic fail_and_stop();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		fail_and_stop();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, expected);
			fail_and_stop();
		end
	endtask

	// ******************************
	// Program loading and reset
	// ******************************
	task automatic load_program(input prog_entry_t entry);
		logic [XLEN-1:0] word;
		@(negedge clk);
		reset = 1'b1;
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			// Unused words get junk that must never run
			if (a < entry.n_words)
				word = PROG_WORDS[entry.base + a];
			else
				word = $urandom;
			imem_we = 1'b1;
			imem_addr = AW'(a);
			imem_wdata = word;
			@(negedge clk);
		end
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
	endtask

	task automatic hold_reset();
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("valid", valid, 1'b0);
			check_value("finished", finished, 1'b0);
			check_value("pc", pc, RESET_PC);
		end
		reset = 1'b0;
	endtask

	task automatic run_program(input int idx);
		prog_entry_t entry;
		int          edges;
		int          cycles;
		int          strobes;
		bit          done;
		entry = PROG_TABLE[idx];
		load_program(entry);
		hold_reset();

		edges = 0;
		while (valid !== 1'b1) begin
			if (edges >= VALID_TIMEOUT) begin
				abort_run($sformatf("program %0d: no valid strobe after reset", idx));
			end else begin
				@(negedge clk);
				edges++;
				if (valid !== 1'b1)
					check_value("finished", finished, 1'b0);
			end
		end
		check_value("first valid edge", edges, FIRST_VALID_EDGE);
		check_value("pc", pc, RESET_PC);

		// One valid cycle is seen at exactly one falling edge
		strobes = 0;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			if (valid === 1'b1)
				strobes++;
			if (finished === 1'b1) begin
				done = 1'b1;
			end else if (cycles >= RUN_TIMEOUT) begin
				abort_run($sformatf("program %0d: finished not seen in time", idx));
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
		check_value("valid", valid, 1'b1);
		check_value("halt_ret", halt_ret, entry.exp_ret);
		check_value("pc", pc, entry.exp_pc);
		check_value("valid strobes", strobes, entry.exp_strobes);

		// Core stays frozen on the ebreak
		repeat (HALT_CYCLES) begin
			@(negedge clk);
			check_value("valid", valid, 1'b0);
			check_value("finished", finished, 1'b0);
			check_value("pc", pc, entry.exp_pc);
		end
	endtask

	initial begin
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		void'($urandom(SEED));

		for (int i = 0; i < N_PROGS; i++)
			run_program(i);

		$display("** PASS **");
		$finish;
	end

endmodule
